//--- files.f
+incdir+verilog
verilog/sap_pkg.sv
verilog/sap_config_regs.sv
verilog/sap_program_rom.sv
verilog/sap_controller.sv
verilog/sap_datapath.sv
verilog/spi_frame_tx.sv
verilog/sap_top.sv
verification/sap_props.sv
verification/sap_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sap_tb
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/sap_tb.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_tb;
    import sap_pkg::*;

    localparam logic [15:0] STAGE_DIV = 16'd400;    // Longer than one SPI frame
    localparam int MAX_CYCLES = 8 * 5 * `SAP_STAGES * (int'(STAGE_DIV) + 1) + 20000;

    logic                    clk = 1'b0;
    logic                    reset;
    wb_req_t                 wb_req;
    wb_rsp_t                 wb_rsp;
    logic                    sclk;
    logic                    mosi;
    logic                    cs_n;
    int                      errors = 0;
    int                      cycles = 0;
    integer                  seed = 32'h9d57a9f7;
    logic [`SAP_FRAME_W-1:0] rx_shift;
    logic                    frame_open = 1'b0;
    int                      rise_cnt = 0;
    int                      frame_count = 0;
    status_frame_t           last_frame;
    logic                    have_prev = 1'b0;      // Stage history valid for this run
    int                      prev_stage = 0;
    logic                    song_seen [16];

    sap_top i_sap_top (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .sclk   (sclk),
        .mosi   (mosi),
        .cs_n   (cs_n)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic expect_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // One classic cycle, request dropped on the falling edge that sees ack
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;
        @(negedge clk);
        expect_eq("wb_rsp.ack", int'(wb_rsp.ack), 0);
    endtask

    task automatic wait_halted();
        logic [15:0] st;
        st = '0;
        while (!st[0]) begin
            repeat (50) @(negedge clk);
            wb_access(1'b0, `SAP_REG_STATUS, 16'd0, st);
        end
    endtask

    // Restart with a new program and let it run to HLT and its last frame
    task automatic run_program(input logic [2:0] prog);
        logic [15:0] rdat;
        have_prev = 1'b0;
        wb_access(1'b1, `SAP_REG_PROG, {13'd0, prog}, rdat);
        wait_halted();
        while (!cs_n) @(negedge clk);
    endtask

    always @(negedge cs_n) begin
        frame_open = 1'b1;
        rise_cnt   = 0;
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_shift = {rx_shift[`SAP_FRAME_W-2:0], mosi};   // MSB first
            rise_cnt++;
        end
    end

    always @(posedge cs_n) begin
        if (frame_open) begin
            frame_open = 1'b0;
            last_frame = rx_shift;
            frame_count++;
            expect_eq("sclk rising edges", rise_cnt, `SAP_FRAME_W);
            if (have_prev) begin
                expect_eq("frame.stage", int'(last_frame.stage),
                          (prev_stage + 1) % `SAP_STAGES);
            end
            prev_stage = int'(last_frame.stage);
            have_prev  = 1'b1;
            if (last_frame.sng_en) song_seen[last_frame.operand] = 1'b1;
        end
    end

    initial begin
        logic [15:0] rdat;
        logic [3:0]  song;
        int          order [4];
        int          j;
        int          tmp;
        int          count_before;
        int          total;

        reset  = 1'b1;
        wb_req = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        expect_eq("cs_n", int'(cs_n), 1);
        expect_eq("sclk", int'(sclk), 0);
        expect_eq("wb_rsp.ack", int'(wb_rsp.ack), 0);

        wb_access(1'b1, `SAP_REG_DIV, STAGE_DIV, rdat);
        wb_access(1'b0, `SAP_REG_DIV, 16'd0, rdat);
        expect_eq("STAGE_DIV", int'(rdat), int'(STAGE_DIV));
        wb_access(1'b0, `SAP_REG_PROG, 16'd0, rdat);
        expect_eq("PROG_SEL", int'(rdat), 0);
        wb_access(1'b0, `SAP_REG_STATUS, 16'd0, rdat);
        expect_eq("STATUS.halted", int'(rdat[0]), 0);

        // 10 + 4, halted in stage 3 of HLT
        run_program(3'd0);
        wb_access(1'b0, `SAP_REG_STATUS, 16'd0, rdat);
        expect_eq("STATUS", int'(rdat), 7);
        expect_eq("frame.a", int'(last_frame.a), 10);
        expect_eq("frame.b", int'(last_frame.b), 4);
        expect_eq("frame.acc", int'(last_frame.acc), 14);
        expect_eq("frame.pc", int'(last_frame.pc), 5);

        run_program(3'd1);
        expect_eq("frame.a", int'(last_frame.a), 10);
        expect_eq("frame.b", int'(last_frame.b), 4);
        expect_eq("frame.acc", int'(last_frame.acc), 6);

        order = '{2, 3, 4, 5};
        for (int i = 3; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < 4; k++) begin
            song            = 4'(order[k]);
            song_seen[song] = 1'b0;
            run_program(song[2:0]);
            expect_eq($sformatf("song %0d requested", song), int'(song_seen[song]), 1);
            count_before = frame_count;
            repeat (2 * (int'(STAGE_DIV) + 1)) @(negedge clk);
            expect_eq("frames after halt", frame_count, count_before);
            expect_eq("cs_n", int'(cs_n), 1);
        end

        total = errors + i_sap_top.i_sap_props.fail_count;
        $display("Done: %0d value errors, %0d assertion failures, %0d frames",
                 errors, i_sap_top.i_sap_props.fail_count, frame_count);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/sap_props.sv
`timescale 1ns/1ps

module sap_props (
    input logic                   clk,
    input logic                   reset,
    input sap_pkg::wb_req_t       wb_req,
    input sap_pkg::wb_rsp_t       wb_rsp,
    input logic                   sclk,
    input logic                   cs_n,
    input logic                   halted,
    input logic                   frame_req,
    input logic [2:0]             prog_sel,
    input sap_pkg::status_frame_t frame
);

    int fail_count = 0;

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack) else begin
        $error("ack held longer than one cycle");
        fail_count++;
    end

    ack_requested: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)) else begin
        $error("ack without a bus request");
        fail_count++;
    end

    // SPI mode 0 idles low
    sclk_idle: assert property (@(posedge clk) disable iff (reset)
        cs_n |-> !sclk) else begin
        $error("sclk high while cs_n is high");
        fail_count++;
    end

    quiet_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !frame_req) else begin
        $error("frame requested while halted");
        fail_count++;
    end

    add_result: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) && prog_sel == 3'd0 |-> frame.acc == 8'd14 && frame.pc == 8'd5)
        else begin
        $error("add program halted with a wrong accumulator or PC");
        fail_count++;
    end

    sub_result: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) && prog_sel == 3'd1 |-> frame.acc == 8'd6) else begin
        $error("sub program halted with a wrong accumulator");
        fail_count++;
    end

endmodule

bind sap_top sap_props i_sap_props (.*);

//--- verilog/sap_top.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_top (
    input  logic             clk,
    input  logic             reset,
    input  sap_pkg::wb_req_t wb_req,
    output sap_pkg::wb_rsp_t wb_rsp,
    output logic             sclk,
    output logic             mosi,
    output logic             cs_n
);
    import sap_pkg::*;

    logic [2:0]             prog_sel;
    logic                   stage_tick;
    logic                   restart;
    logic                   halted;
    logic                   frame_req;
    stage_t                 stage;
    ctrl_word_t             ctrl;
    opcode_e                opcode;
    logic [`SAP_ADDR_W-1:0] mem_addr;
    logic [`SAP_DATA_W-1:0] mem_data;
    status_frame_t          frame;

    sap_config_regs i_config_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .halted     (halted),
        .stage      (stage),
        .wb_rsp     (wb_rsp),
        .prog_sel   (prog_sel),
        .stage_tick (stage_tick),
        .restart    (restart)
    );

    sap_controller i_controller (
        .clk        (clk),
        .reset      (reset),
        .restart    (restart),
        .stage_tick (stage_tick),
        .opcode     (opcode),
        .ctrl       (ctrl),
        .stage      (stage),
        .halted     (halted),
        .frame_req  (frame_req)
    );

    sap_datapath i_datapath (
        .clk        (clk),
        .reset      (reset),
        .restart    (restart),
        .stage_tick (stage_tick),
        .ctrl       (ctrl),
        .mem_data   (mem_data),
        .mem_addr   (mem_addr),
        .opcode     (opcode),
        .stage_in   (stage),
        .frame      (frame)
    );

    sap_program_rom i_program_rom (
        .prog_sel   (prog_sel),
        .addr       (mem_addr),
        .data       (mem_data)
    );

    spi_frame_tx i_spi_frame_tx (
        .clk        (clk),
        .reset      (reset),
        .start      (frame_req),
        .frame      (frame),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n)
    );

endmodule

//--- verilog/spi_frame_tx.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module spi_frame_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  sap_pkg::status_frame_t frame,
    output logic                   sclk,
    output logic                   mosi,
    output logic                   cs_n
);

    localparam int DIV_W  = $clog2(`SAP_SPI_DIV + 1);
    localparam int EDGE_W = $clog2(`SAP_FRAME_W + 1);

    logic [DIV_W-1:0]        div_cnt;
    logic [EDGE_W-1:0]       edge_cnt;     // SCLK rising edges so far
    logic [`SAP_FRAME_W-1:0] shift;
    logic                    busy;

    assign mosi = shift[`SAP_FRAME_W-1];   // First bit valid as cs_n falls

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            shift    <= '0;
        end else if (!busy) begin
            if (start) begin
                busy     <= 1'b1;
                cs_n     <= 1'b0;
                shift    <= frame;
                div_cnt  <= '0;
                edge_cnt <= '0;
            end
        end else if (cs_n) begin
            busy <= 1'b0;                  // One idle cycle after cs_n rises
        end else if (div_cnt == DIV_W'(`SAP_SPI_DIV - 1)) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (!sclk) begin
                edge_cnt <= edge_cnt + 1'b1;
            end else begin
                // Falling edge, next bit out
                shift <= {shift[`SAP_FRAME_W-2:0], 1'b0};
                if (edge_cnt == EDGE_W'(`SAP_FRAME_W)) cs_n <= 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/sap_datapath.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   restart,
    input  logic                   stage_tick,
    input  sap_pkg::ctrl_word_t    ctrl,
    input  logic [`SAP_DATA_W-1:0] mem_data,
    output logic [`SAP_ADDR_W-1:0] mem_addr,
    output sap_pkg::opcode_e       opcode,
    input  sap_pkg::stage_t        stage_in,
    output sap_pkg::status_frame_t frame
);
    import sap_pkg::*;

    localparam int PAD_W = `SAP_DATA_W - `SAP_ADDR_W;

    logic [`SAP_ADDR_W-1:0] pc;
    logic [`SAP_ADDR_W-1:0] mar;
    logic [`SAP_DATA_W-1:0] ir;
    logic [`SAP_DATA_W-1:0] a_reg;
    logic [`SAP_DATA_W-1:0] b_reg;
    logic [`SAP_DATA_W-1:0] acc;
    logic [`SAP_DATA_W-1:0] bus;
    logic [`SAP_DATA_W-1:0] alu;
    logic [`SAP_ADDR_W-1:0] operand;

    assign operand = ir[`SAP_ADDR_W-1:0];

    // The microcode enables one source at a time
    always_comb begin
        if (ctrl.pc_en) begin
            bus = {{PAD_W{1'b0}}, pc};
        end else if (ctrl.mem_en) begin
            bus = mem_data;
        end else if (ctrl.ir_en) begin
            bus = {{PAD_W{1'b0}}, operand};
        end else if (ctrl.a_en) begin
            bus = a_reg;
        end else begin
            bus = '0;
        end
    end

    assign alu = ctrl.alu_sub ? a_reg - b_reg : a_reg + b_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            mar   <= '0;
            ir    <= '0;
            a_reg <= '0;
            b_reg <= '0;
            acc   <= '0;
        end else if (restart) begin
            pc    <= '0;
            mar   <= '0;
            ir    <= '0;
            a_reg <= '0;
            b_reg <= '0;
            acc   <= '0;
        end else if (stage_tick) begin
            if (ctrl.pc_inc)   pc    <= pc + 1'b1;
            if (ctrl.mar_load) mar   <= bus[`SAP_ADDR_W-1:0];
            if (ctrl.ir_load)  ir    <= bus;
            if (ctrl.a_load)   a_reg <= bus;
            if (ctrl.b_load)   b_reg <= bus;
            if (ctrl.acc_load) acc   <= alu;
        end
    end

    assign mem_addr = mar;
    assign opcode   = opcode_e'(ir[`SAP_DATA_W-1:`SAP_ADDR_W]);

    always_comb begin
        frame.a       = a_reg;
        frame.b       = b_reg;
        frame.acc     = acc;
        frame.pc      = {{PAD_W{1'b0}}, pc};
        frame.sng_en  = ctrl.sng_en;      // Strobe of the stage about to run
        frame.operand = operand;
        frame.stage   = stage_in;
    end

endmodule

//--- verilog/sap_controller.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                restart,
    input  logic                stage_tick,
    input  sap_pkg::opcode_e    opcode,
    output sap_pkg::ctrl_word_t ctrl,
    output sap_pkg::stage_t     stage,
    output logic                halted,
    output logic                frame_req
);
    import sap_pkg::*;

    logic advance;

    // A tick is ignored once HLT has been decoded
    assign advance = stage_tick && !halted && !ctrl.hlt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage     <= '0;
            halted    <= 1'b0;
            frame_req <= 1'b0;
        end else if (restart) begin
            stage     <= '0;
            halted    <= 1'b0;
            frame_req <= 1'b0;
        end else begin
            if (ctrl.hlt) halted <= 1'b1;
            if (advance) begin
                stage <= (stage == stage_t'(`SAP_STAGES - 1)) ? '0 : stage + 1'b1;
            end
            frame_req <= advance;                 // Registers settle first, then sample
        end
    end

    // Microcode: fetch in stages 0 to 2, execute in 3 to 5
    always_comb begin
        ctrl = '0;
        case (stage)
            3'd0: begin
                ctrl.pc_en    = 1'b1;
                ctrl.mar_load = 1'b1;
            end
            3'd1: ctrl.pc_inc = 1'b1;
            3'd2: begin
                ctrl.mem_en  = 1'b1;
                ctrl.ir_load = 1'b1;
            end
            3'd3: begin
                case (opcode)
                    LDA, ADD, SUB: begin
                        ctrl.ir_en    = 1'b1;     // Operand addresses the data byte
                        ctrl.mar_load = 1'b1;
                    end
                    OUT:     ctrl.a_en   = 1'b1;  // Nothing latches it
                    SNG:     ctrl.sng_en = 1'b1;
                    HLT:     ctrl.hlt    = 1'b1;
                    default: ;
                endcase
            end
            3'd4: begin
                ctrl.mem_en = (opcode == LDA) || (opcode == ADD) || (opcode == SUB);
                ctrl.a_load = (opcode == LDA);
                ctrl.b_load = (opcode == ADD) || (opcode == SUB);
            end
            3'd5: begin
                ctrl.acc_load = (opcode == ADD) || (opcode == SUB);
                ctrl.alu_sub  = (opcode == SUB);
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/sap_program_rom.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_program_rom (
    input  logic [2:0]             prog_sel,
    input  logic [`SAP_ADDR_W-1:0] addr,
    output logic [`SAP_DATA_W-1:0] data
);
    import sap_pkg::*;

    // LDA 15, op 14, OUT, SNG 0, HLT with data bytes 4 and 10 at the top
    function automatic logic [7:0] arith_byte(input opcode_e op, input logic [3:0] a);
        logic [7:0] val;
        case (a)
            4'd0:    val = {LDA, 4'd15};
            4'd1:    val = {op, 4'd14};
            4'd2:    val = {OUT, 4'd0};
            4'd3:    val = {SNG, 4'd0};
            4'd4:    val = {HLT, 4'd0};
            4'd14:   val = 8'd4;              // B operand
            4'd15:   val = 8'd10;             // A operand
            default: val = 8'd0;
        endcase
        return val;
    endfunction

    // Song request n, then stop
    function automatic logic [7:0] song_byte(input logic [3:0] n, input logic [3:0] a);
        logic [7:0] val;
        case (a)
            4'd0:    val = {SNG, n};
            4'd1:    val = {HLT, 4'd0};
            default: val = 8'd0;
        endcase
        return val;
    endfunction

    always_comb begin
        case (prog_sel)
            3'd1:    data = arith_byte(SUB, addr);
            3'd2,
            3'd3,
            3'd4,
            3'd5:    data = song_byte({1'b0, prog_sel}, addr);
            default: data = arith_byte(ADD, addr);  // 0, 6 and 7 run the add program
        endcase
    end

endmodule

//--- verilog/sap_config_regs.sv
`timescale 1ns/1ps
`include "sap_params.svh"

module sap_config_regs (
    input  logic             clk,
    input  logic             reset,
    input  sap_pkg::wb_req_t wb_req,
    input  logic             halted,
    input  sap_pkg::stage_t  stage,
    output sap_pkg::wb_rsp_t wb_rsp,
    output logic [2:0]       prog_sel,
    output logic             stage_tick,
    output logic             restart
);

    logic [15:0] stage_div;
    logic [15:0] tick_cnt;
    logic        access;
    logic [15:0] rd_data;

    // New strobe only, so ack never stretches past one cycle
    assign access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    always_comb begin
        case (wb_req.adr)
            `SAP_REG_PROG:   rd_data = {13'd0, prog_sel};
            `SAP_REG_DIV:    rd_data = stage_div;
            `SAP_REG_STATUS: rd_data = {12'd0, stage, halted};
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_rsp    <= '0;
            prog_sel  <= '0;
            stage_div <= `SAP_STAGE_DIV_RST;
            restart   <= 1'b0;
        end else begin
            wb_rsp.ack <= access;
            restart    <= 1'b0;
            if (access) begin
                wb_rsp.dat <= rd_data;
                if (wb_req.we) begin
                    case (wb_req.adr)
                        `SAP_REG_PROG: begin
                            prog_sel <= wb_req.dat[2:0];
                            restart  <= 1'b1;         // CPU starts over at address 0
                        end
                        `SAP_REG_DIV:  stage_div <= wb_req.dat;
                        default:       ;              // STATUS is read only
                    endcase
                end
            end
        end
    end

    // Stage tick every stage_div+1 cycles
    // >= keeps the counter sane when the divider is lowered mid count
    assign stage_tick = (tick_cnt >= stage_div);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (restart || stage_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 16'd1;
        end
    end

endmodule

//--- verilog/sap_pkg.sv
`include "sap_params.svh"

package sap_pkg;

    typedef enum logic [3:0] {
        LDA = 4'd0,
        ADD = 4'd1,
        SUB = 4'd2,
        SNG = 4'd3,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // One strobe per datapath action
    typedef struct packed {
        logic sng_en;
        logic hlt;
        logic pc_inc;
        logic pc_en;
        logic mar_load;
        logic mem_en;
        logic ir_load;
        logic ir_en;
        logic a_load;
        logic a_en;
        logic b_load;
        logic alu_sub;
        logic acc_en;
        logic acc_load;
    } ctrl_word_t;

    typedef logic [$clog2(`SAP_STAGES)-1:0] stage_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // Shifted out MSB first
    typedef struct packed {
        logic [`SAP_DATA_W-1:0] a;
        logic [`SAP_DATA_W-1:0] b;
        logic [`SAP_DATA_W-1:0] acc;
        logic [`SAP_DATA_W-1:0] pc;
        logic                   sng_en;
        logic [3:0]             operand;
        stage_t                 stage;
    } status_frame_t;

endpackage

//--- verilog/sap_params.svh
`ifndef SAP_PARAMS_SVH
`define SAP_PARAMS_SVH

// Datapath widths
`define SAP_DATA_W        8
`define SAP_ADDR_W        4

// Microcode ring length
`define SAP_STAGES        6

// Status stream
`define SAP_FRAME_W       40
`define SAP_SPI_DIV       4       // clk cycles per SCLK half period

// Stage length after reset, in clk cycles minus one
`define SAP_STAGE_DIV_RST 16'd1000

// Register map
`define SAP_REG_PROG      2'd0
`define SAP_REG_DIV       2'd1
`define SAP_REG_STATUS    2'd2

`endif
